// File: hw/packer_pkg.sv
package packer_pkg;

	// Width of one FIFO entry which holds one assembled serial byte
	localparam int byte_w = 8;

	// Width of one output word made of two packed bytes
	localparam int word_w = 16;

	// Number of byte entries held in the FIFO
	localparam int fifo_depth = 16;

	// Pointer width so that pointers wrap on their own at fifo_depth
	localparam int fifo_aw = $clog2(fifo_depth);

	// One serial beat
	// val only counts in a cycle where strobe is high
	typedef struct packed {
		logic strobe;
		logic val;
	} ser_bit_t;

	// Completed byte from the deserializer
	// strobe is one cycle wide and writes data into the FIFO
	typedef struct packed {
		logic              strobe;
		logic [byte_w-1:0] data;
	} byte_beat_t;

	// Output beat of the packer
	// sum already includes data in the cycle where strobe is high
	typedef struct packed {
		logic              strobe;
		logic [word_w-1:0] data;
		logic [word_w-1:0] sum;
	} word_beat_t;

endpackage

// File: hw/serial_deserializer.sv
`timescale 1ns/1ps

module serial_deserializer import packer_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  ser_bit_t   ser_in,
	output byte_beat_t byte_out
);

	// Bit position of the next incoming bit within the current byte
	logic [2:0] cnt_q;

	// Partial byte where the first received bit ends up in bit 0
	logic [byte_w-1:0] shift_q;
	logic [byte_w-1:0] shift_nxt;

	// Completed byte and its write strobe
	logic [byte_w-1:0] data_q;
	logic              strobe_q;

	// Set on the beat that carries the eighth bit
	logic byte_done;

	// New bits enter at the top and move down, so bit 0 is the oldest
	assign shift_nxt = {ser_in.val, shift_q[byte_w-1:1]};

	assign byte_done = ser_in.strobe && (cnt_q == 3'(byte_w - 1));

	// Bit counter wraps back to zero after the last bit of a byte
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt_q <= '0;
		end else if (ser_in.strobe) begin
			cnt_q <= cnt_q + 3'd1;
		end
	end

	// Shift register for the byte under assembly
	always_ff @(posedge clk) begin
		if (ser_in.strobe) begin
			shift_q <= shift_nxt;
		end
	end

	// Capture the full byte on the edge that takes its last bit
	always_ff @(posedge clk) begin
		if (byte_done) begin
			data_q <= shift_nxt;
		end
	end

	// One cycle strobe right after the completing edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			strobe_q <= 1'b0;
		end else begin
			strobe_q <= byte_done;
		end
	end

	assign byte_out.strobe = strobe_q;
	assign byte_out.data   = data_q;

endmodule

// File: hw/width_fifo.sv
`timescale 1ns/1ps

module width_fifo import packer_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  byte_beat_t        byte_in,
	input  logic              rd_strobe,
	output logic              word_avail,
	output logic [word_w-1:0] rd_word,
	output logic              rd_valid
);

	// Byte storage
	logic [byte_w-1:0] mem [fifo_depth];

	// Pointers wrap naturally at fifo_depth
	logic [fifo_aw-1:0] wr_ptr_q;
	logic [fifo_aw-1:0] rd_ptr_q;
	logic [fifo_aw-1:0] rd_ptr_hi;

	// Stored byte count needs one bit more than the pointers to reach fifo_depth
	logic [fifo_aw:0] count_q;

	// Registered output word and its valid flag
	logic [word_w-1:0] word_q;
	logic              valid_q;

	logic wr_en;
	logic rd_en;

	assign wr_en = byte_in.strobe;

	// The consumer only asks when a word is there
	// no count check here
	assign rd_en = rd_strobe;

	// Second byte of the word sits right after the read pointer
	assign rd_ptr_hi = rd_ptr_q + 1'b1;

	// A word needs two stored bytes
	assign word_avail = (count_q >= (fifo_aw + 1)'(2));

	// Write side
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr_q] <= byte_in.data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr_q <= '0;
		end else if (wr_en) begin
			wr_ptr_q <= wr_ptr_q + 1'b1;
		end
	end

	// Read side takes two bytes per request
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr_q <= '0;
		end else if (rd_en) begin
			rd_ptr_q <= rd_ptr_q + fifo_aw'(2);
		end
	end

	// Older byte goes low, younger byte goes high
	always_ff @(posedge clk) begin
		if (rd_en) begin
			word_q <= {mem[rd_ptr_hi], mem[rd_ptr_q]};
		end
	end

	// Valid follows the request by one edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= rd_en;
		end
	end

	// Count update for each mix of write and read
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count_q <= '0;
		end else begin
			unique case ({wr_en, rd_en})
				// Write only adds one byte
				2'b10: count_q <= count_q + 1'b1;
				// Read only takes two bytes out
				2'b01: count_q <= count_q - (fifo_aw + 1)'(2);
				// Both at once take one byte out net
				2'b11: count_q <= count_q - 1'b1;
				// Idle
				default: count_q <= count_q;
			endcase
		end
	end

	assign rd_word  = word_q;
	assign rd_valid = valid_q;

endmodule

// File: hw/word_checksum.sv
`timescale 1ns/1ps

module word_checksum import packer_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              word_avail,
	input  logic [word_w-1:0] rd_word,
	input  logic              rd_valid,
	input  logic              sum_clear,
	output logic              rd_strobe,
	output word_beat_t        word_out
);

	// Registered output word and strobe
	logic [word_w-1:0] data_q;
	logic              strobe_q;

	// Running sum including the word currently shown
	logic [word_w-1:0] sum_q;

	// Sum as seen outside this cycle after any clear
	logic [word_w-1:0] sum_out;

	// Word that joins the sum at the next edge
	logic [word_w-1:0] add_word;

	// Pull a word as soon as two bytes are buffered
	assign rd_strobe = word_avail;

	// A clear drops everything older than the word shown now
	// so that word starts the new sum on its own
	always_comb begin
		if (sum_clear) begin
			sum_out = strobe_q ? data_q : '0;
		end else begin
			sum_out = sum_q;
		end
	end

	assign add_word = rd_valid ? rd_word : '0;

	// Sum wraps modulo 2^word_w
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sum_q <= '0;
		end else begin
			sum_q <= sum_out + add_word;
		end
	end

	// Word payload
	always_ff @(posedge clk) begin
		if (rd_valid) begin
			data_q <= rd_word;
		end
	end

	// Output strobe one edge after the FIFO read data
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			strobe_q <= 1'b0;
		end else begin
			strobe_q <= rd_valid;
		end
	end

	assign word_out.strobe = strobe_q;
	assign word_out.data   = data_q;
	assign word_out.sum    = sum_out;

endmodule

// File: hw/serial_packer_top.sv
`timescale 1ns/1ps

module serial_packer_top import packer_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  ser_bit_t   ser_in,
	input  logic       sum_clear,
	output word_beat_t word_out
);

	// Bytes from the deserializer into the FIFO
	byte_beat_t byte_beat;

	// FIFO read interface towards the checksum stage
	logic              word_avail;
	logic [word_w-1:0] rd_word;
	logic              rd_valid;
	logic              rd_strobe;

	// Serial bits to bytes with the first bit in bit 0
	serial_deserializer u_serial_deserializer (
		.clk      (clk),
		.arst_n   (arst_n),
		.ser_in   (ser_in),
		.byte_out (byte_beat)
	);

	// Buffer taking bytes in and giving words out
	width_fifo u_width_fifo (
		.clk        (clk),
		.arst_n     (arst_n),
		.byte_in    (byte_beat),
		.rd_strobe  (rd_strobe),
		.word_avail (word_avail),
		.rd_word    (rd_word),
		.rd_valid   (rd_valid)
	);

	// Drains words and tracks the running sum
	word_checksum u_word_checksum (
		.clk        (clk),
		.arst_n     (arst_n),
		.word_avail (word_avail),
		.rd_word    (rd_word),
		.rd_valid   (rd_valid),
		.sum_clear  (sum_clear),
		.rd_strobe  (rd_strobe),
		.word_out   (word_out)
	);

endmodule

// File: test/packer_checker.sv
`timescale 1ns/1ps

module packer_checker import packer_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  ser_bit_t   ser_in,
	input  logic       sum_clear,
	input  word_beat_t word_out,
	output int         errors,
	output int         words_seen,
	output int         clear_hits
);

	// Bytes rebuilt from the serial stream with the oldest first
	logic [byte_w-1:0] byte_q [$];

	// Byte under assembly and how many of its bits are in
	logic [byte_w-1:0] part_byte;
	int                part_bits;

	// Model of the running sum
	logic [word_w-1:0] model_sum;

	// Scratch for one expected output beat
	logic [byte_w-1:0] lo_byte;
	logic [byte_w-1:0] hi_byte;
	word_beat_t        exp_beat;

	// Two bytes make a word with the older one low
	// Sum wraps at 16 bits
	function automatic word_beat_t expect_beat(
		input logic [byte_w-1:0] lo,
		input logic [byte_w-1:0] hi,
		input logic [word_w-1:0] prev_sum
	);
		word_beat_t beat;
		beat.strobe = 1'b1;
		beat.data   = {hi, lo};
		beat.sum    = prev_sum + {hi, lo};
		return beat;
	endfunction

	initial begin
		errors     = 0;
		words_seen = 0;
		clear_hits = 0;
	end

	// Inputs still hold their pre-edge values at the rising edge
	always @(posedge clk) begin
		if (!arst_n) begin
			byte_q.delete();
			part_byte = '0;
			part_bits = 0;
			model_sum = '0;
		end else begin
			// Clear first so that a word in the same cycle starts the new sum
			if (sum_clear) begin
				model_sum = '0;
			end
			if (word_out.strobe) begin
				words_seen++;
				if (sum_clear) begin
					clear_hits++;
				end
				if (byte_q.size() < 2) begin
					errors++;
					$display("Word strobe at %0t with fewer than two bytes sent", $time);
				end else begin
					lo_byte = byte_q.pop_front();
					hi_byte = byte_q.pop_front();
					exp_beat = expect_beat(lo_byte, hi_byte, model_sum);
					model_sum = exp_beat.sum;
					if (word_out.data !== exp_beat.data) begin
						errors++;
						$display("Fail word_out.data: got %h, expected %h",
							word_out.data, exp_beat.data);
					end
					if (word_out.sum !== exp_beat.sum) begin
						errors++;
						$display("Fail word_out.sum: got %h, expected %h",
							word_out.sum, exp_beat.sum);
					end
				end
			end
			// First bit of a byte lands in bit 0
			if (ser_in.strobe) begin
				part_byte[part_bits] = ser_in.val;
				part_bits++;
				if (part_bits == byte_w) begin
					byte_q.push_back(part_byte);
					part_bits = 0;
				end
			end
		end
	end

endmodule

// File: test/tb_serial_packer.sv
`timescale 1ns/1ps

module tb_serial_packer import packer_pkg::*; ();

	localparam int clk_period   = 20;
	localparam int reset_cycles = 8;
	// Longest spacing of one random bit in cycles with its strobe included
	localparam int max_gap      = 6;
	localparam int dir_bits     = 64;
	localparam int full_bits    = 256;
	localparam int rand_bits    = 640;
	localparam int total_bits   = dir_bits + full_bits + rand_bits;
	localparam int timeout_cycles = total_bits * max_gap + 100;

	logic       clk;
	logic       arst_n;
	ser_bit_t   ser_in;
	logic       sum_clear;
	word_beat_t word_out;

	// Results from the checker
	int errors;
	int words_seen;
	int clear_hits;

	int     tb_errors;
	int     bits_sent;
	integer seed;

	logic rnd_bit;
	int   rnd_gap;
	logic rnd_clr;

	serial_packer_top u_serial_packer_top (
		.clk       (clk),
		.arst_n    (arst_n),
		.ser_in    (ser_in),
		.sum_clear (sum_clear),
		.word_out  (word_out)
	);

	packer_checker u_packer_checker (
		.clk        (clk),
		.arst_n     (arst_n),
		.ser_in     (ser_in),
		.sum_clear  (sum_clear),
		.word_out   (word_out),
		.errors     (errors),
		.words_seen (words_seen),
		.clear_hits (clear_hits)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			ser_in    <= '0;
			sum_clear <= 1'b0;
		end
	endtask

	// One valid bit followed by gap empty cycles
	task automatic send_bit(input logic bit_val, input int gap, input logic clr);
		@(posedge clk);
		ser_in.strobe <= 1'b1;
		ser_in.val    <= bit_val;
		sum_clear     <= clr;
		bits_sent++;
		repeat (gap) begin
			@(posedge clk);
			ser_in    <= '0;
			sum_clear <= 1'b0;
		end
	endtask

	// Sends LSB first
	// an nbits below 8 leaves the byte unfinished
	task automatic send_byte(input logic [7:0] value, input int gap, input int nbits);
		for (int i = 0; i < nbits; i++) begin
			send_bit(value[i], gap, 1'b0);
		end
	endtask

	task automatic clear_pulse();
		@(posedge clk);
		sum_clear <= 1'b1;
		@(posedge clk);
		sum_clear <= 1'b0;
	endtask

	initial begin
		arst_n    = 1'b0;
		ser_in    = '0;
		sum_clear = 1'b0;
		tb_errors = 0;
		bits_sent = 0;
		seed      = 32'he948;
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1;
		idle(2);

		// No word may come out after only fifteen bits
		send_byte(8'h01, 1, 8);
		send_byte(8'h80, 1, 7);
		idle(10);
		@(negedge clk);
		if (words_seen != 0) begin
			tb_errors++;
			$display("A word came out before sixteen valid bits were sent");
		end
		// Top bit of 0x80 completes the first word
		send_bit(1'b1, 1, 1'b0);
		send_byte(8'hA5, 1, 8);
		send_byte(8'h3C, 1, 8);
		idle(10);

		// A clear while idle lets the next word start the sum alone
		clear_pulse();
		idle(4);
		send_byte(8'hFF, 1, 8);
		send_byte(8'hFF, 1, 8);
		idle(10);

		// Word strobe shows 4 edges after its last bit is driven
		send_byte(8'h34, 0, 8);
		send_byte(8'h12, 0, 8);
		idle(3);
		clear_pulse();
		idle(10);

		// Full rate stream
		for (int i = 0; i < full_bits; i++) begin
			rnd_bit = $random(seed) & 1;
			send_bit(rnd_bit, 0, 1'b0);
		end
		idle(10);

		// Random gaps with the odd clear mixed in
		for (int i = 0; i < rand_bits; i++) begin
			rnd_bit = $random(seed) & 1;
			rnd_gap = $unsigned($random(seed)) % max_gap;
			rnd_clr = (($random(seed) & 15) == 0);
			send_bit(rnd_bit, rnd_gap, rnd_clr);
		end
		idle(1);

		// Drain and then wait a margin to catch any extra word
		while (words_seen < bits_sent / 16) @(negedge clk);
		idle(10);
		@(negedge clk);
		if (words_seen != bits_sent / 16) begin
			tb_errors++;
			$display("Fail words_seen: got %h, expected %h", words_seen, bits_sent / 16);
		end
		if (clear_hits == 0) begin
			tb_errors++;
			$display("No sum_clear fell in the same cycle as an emitted word");
		end
		$display("Summary: %0d checker errors, %0d testbench errors, %0d words checked",
			errors, tb_errors, words_seen);
		if (errors + tb_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("Run did not finish within %0d cycles", timeout_cycles);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: build.f
hw/packer_pkg.sv
hw/serial_deserializer.sv
hw/width_fifo.sv
hw/word_checksum.sv
hw/serial_packer_top.sv
test/packer_checker.sv
test/tb_serial_packer.sv
